// ==== verilog.f ====
verilog/bus_cfg_pkg.sv
verilog/mem_ctl_pkg.sv
verilog/mem_stream_if.sv
verilog/pipe_stage.sv
verilog/mem_array_stage.sv
verilog/axi_lite_front.sv
verilog/mem_ctl_top.sv
verif/mem_ctl_checker.sv
verif/mem_ctl_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mem_ctl_tb -f verilog.f -o mem_ctl_sim
out=$(./obj_dir/mem_ctl_sim) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx '=== PASS ==='

// ==== verif/mem_ctl_tb.sv ====
// testbench for the memory controller with clock, reset, seeded traffic, model and checks
`timescale 1ns/10ps
`default_nettype none

module mem_ctl_tb;

  import bus_cfg_pkg::*;

  localparam int mem_words  = 150;
  localparam int drive_dly  = 2;
  localparam int wait_limit = 2000;

  // one outstanding response as the model predicts it
  typedef struct packed {
    logic  is_write;
    data_t data;
    resp_t resp;
    logic  known;
  } exp_rsp_t;

  logic  clk;
  logic  rst;
  logic  awvalid;
  logic  awready;
  addr_t awaddr;
  logic  wvalid;
  logic  wready;
  data_t wdata;
  strb_t wstrb;
  logic  bvalid;
  logic  bready;
  resp_t bresp;
  logic  arvalid;
  logic  arready;
  addr_t araddr;
  logic  rvalid;
  logic  rready;
  data_t rdata;
  resp_t rresp;

  // expected responses in acceptance order
  exp_rsp_t exp_q[$];
  // model words by index
  data_t    model [int];
  int       check_errs   = 0;
  int       timeout_errs = 0;
  int       n_rsp        = 0;
  bit       stall_on     = 1'b0;

  mem_ctl_top #(.mem_words(mem_words)) dut0 (
    .clk, .rst,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // byte address of a word with a random byte offset the DUT ignores
  function automatic addr_t byte_addr(input int idx);
    return (addr_t'(idx) << word_shift) | addr_t'($urandom_range(0, 3));
  endfunction

  // prefill value that depends on every index bit
  function automatic data_t fill_word(input int idx);
    return (data_t'(idx) * 32'h9e3779b1) ^ 32'h5ac30f96;
  endfunction

  // mostly in or just past the array and now and then far beyond it
  function automatic int pick_idx();
    if ($urandom_range(0, 15) == 0) begin
      return 1000 + $urandom_range(0, 99);
    end
    return $urandom_range(0, mem_words + 9);
  endfunction

  task automatic expect_read(input addr_t a);
    exp_rsp_t e;
    int       idx;
    idx        = int'(a >> word_shift);
    e.is_write = 1'b0;
    e.data     = '0;
    e.known    = 1'b1;
    e.resp     = (idx >= mem_words) ? resp_slverr : resp_okay;
    if (idx < mem_words) begin
      if (model.exists(idx)) begin
        e.data = model[idx];
      end else begin
        e.known = 1'b0;
      end
    end
    exp_q.push_back(e);
  endtask

  // byte merge into the model unless the write is refused
  task automatic expect_write(input addr_t a, input data_t d, input strb_t s);
    exp_rsp_t e;
    data_t    w;
    int       idx;
    int       b;
    idx        = int'(a >> word_shift);
    e.is_write = 1'b1;
    e.data     = '0;
    e.known    = 1'b1;
    e.resp     = (idx >= mem_words) ? resp_slverr : resp_okay;
    if (idx < mem_words) begin
      w = model.exists(idx) ? model[idx] : 'x;
      for (b = 0; b < strb_w; b++) begin
        if (s[b]) begin
          w[8*b +: 8] = d[8*b +: 8];
        end
      end
      model[idx] = w;
    end
    exp_q.push_back(e);
  endtask

  task automatic check_rsp(input bit is_write, input data_t d, input resp_t r);
    exp_rsp_t e;
    n_rsp++;
    if (exp_q.size() == 0) begin
      check_errs++;
      $display("CHECK FAILED at %0t: response with nothing outstanding", $time);
      return;
    end
    e = exp_q.pop_front();
    if (e.is_write != is_write) begin
      check_errs++;
      $display("CHECK FAILED at %0t: response on wrong channel, write=%0b", $time, is_write);
    end else if (r !== e.resp) begin
      check_errs++;
      $display("CHECK FAILED at %0t: resp %0h, expected %0h", $time, r, e.resp);
    end else if (!is_write && e.known && d !== e.data) begin
      check_errs++;
      $display("CHECK FAILED at %0t: rdata %h, expected %h", $time, d, e.data);
    end
  endtask

  // called a little after a rising edge and returns at the same phase
  task automatic issue(input bit rd, input addr_t ra, input bit wr, input addr_t wa,
                       input data_t wd, input strb_t ws);
    bit rd_pend;
    bit wr_pend;
    bit rd_take;
    bit wr_take;
    int waited;
    if (timeout_errs != 0) begin
      return;
    end
    rd_pend = rd;
    wr_pend = wr;
    waited  = 0;
    araddr  = ra;
    awaddr  = wa;
    wdata   = wd;
    wstrb   = ws;
    arvalid = rd;
    awvalid = wr;
    wvalid  = wr;
    while (rd_pend || wr_pend) begin
      if (waited >= wait_limit) begin
        timeout_errs++;
        $display("timeout: a request was never accepted, at %0t", $time);
        arvalid = 1'b0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        return;
      end
      // inputs are quiet here so the coming edge transfers exactly this
      @(negedge clk);
      rd_take = rd_pend && arready;
      wr_take = wr_pend && awready && wready;
      if (wr_pend && (awready !== wready)) begin
        check_errs++;
        $display("CHECK FAILED at %0t: awready and wready differ", $time);
      end
      if (wr_take && rd_pend) begin
        check_errs++;
        $display("CHECK FAILED at %0t: write taken while a read waits", $time);
      end
      @(posedge clk);
      // read first as in the DUT
      if (rd_take) begin
        expect_read(ra);
        rd_pend = 1'b0;
      end
      if (wr_take) begin
        expect_write(wa, wd, ws);
        wr_pend = 1'b0;
      end
      #(drive_dly);
      arvalid = rd_pend;
      awvalid = wr_pend;
      wvalid  = wr_pend;
      waited++;
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && timeout_errs == 0) begin
      if (waited >= wait_limit) begin
        timeout_errs++;
        $display("timeout: %0d responses never came back", exp_q.size());
        return;
      end
      @(posedge clk);
      #(drive_dly);
      waited++;
    end
  endtask

  // response side with random stalls on R and B when enabled
  initial begin
    forever begin
      @(negedge clk);
      if (rvalid && rready) begin
        check_rsp(1'b0, rdata, rresp);
      end
      if (bvalid && bready) begin
        check_rsp(1'b1, '0, bresp);
      end
      @(posedge clk);
      #(drive_dly);
      rready = !stall_on || ($urandom_range(0, 3) != 0);
      bready = !stall_on || ($urandom_range(0, 3) != 0);
    end
  end

  initial begin
    int i;
    int ri;
    int wi;
    int kind;
    int sva_errs;
    void'($urandom(32'hb1e4a692));
    rst     = 1'b1;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    bready  = 1'b0;
    repeat (5) @(posedge clk);
    #(drive_dly);
    rst = 1'b0;

    // full words everywhere and then a few read back
    for (i = 0; i < mem_words; i++) begin
      issue(1'b0, '0, 1'b1, byte_addr(i), fill_word(i), '1);
    end
    issue(1'b1, byte_addr(0), 1'b0, '0, '0, '0);
    issue(1'b1, byte_addr(mem_words - 1), 1'b0, '0, '0, '0);
    issue(1'b0, '0, 1'b1, byte_addr(7), 32'hcafe_f00d, '1);
    issue(1'b1, byte_addr(7), 1'b0, '0, '0, '0);

    // partial strobes
    issue(1'b0, '0, 1'b1, byte_addr(20), 32'h1122_3344, 4'b0101);
    issue(1'b1, byte_addr(20), 1'b0, '0, '0, '0);
    issue(1'b0, '0, 1'b1, byte_addr(21), 32'haabb_ccdd, 4'b1000);
    issue(1'b1, byte_addr(21), 1'b0, '0, '0, '0);

    // refused accesses where 261 aliases word 5 in the low index bits
    issue(1'b0, '0, 1'b1, byte_addr(mem_words), 32'hdead_beef, '1);
    issue(1'b0, '0, 1'b1, byte_addr(261), 32'hdead_beef, '1);
    issue(1'b0, '0, 1'b1, 32'hffff_fffc, 32'hdead_beef, '1);
    issue(1'b1, byte_addr(mem_words), 1'b0, '0, '0, '0);
    issue(1'b1, byte_addr(261), 1'b0, '0, '0, '0);
    issue(1'b1, byte_addr(5), 1'b0, '0, '0, '0);
    issue(1'b1, byte_addr(mem_words - 1), 1'b0, '0, '0, '0);
    drain();

    // AR, AW and W together and the read must see the old word
    issue(1'b1, byte_addr(40), 1'b1, byte_addr(40), 32'h0bad_c0de, '1);
    issue(1'b1, byte_addr(40), 1'b0, '0, '0, '0);
    drain();

    // mixed traffic with R and B stalls
    stall_on = 1'b1;
    for (i = 0; i < 400; i++) begin
      kind = $urandom_range(0, 9);
      ri   = pick_idx();
      wi   = pick_idx();
      issue(kind != 4 && kind != 5 && kind != 6 && kind != 7, byte_addr(ri),
            kind >= 4, byte_addr(wi), $urandom, strb_t'($urandom_range(0, 15)));
    end
    drain();
    stall_on = 1'b0;

    sva_errs = dut0.chk0.assert_errs;
    $display("errors: %0d check, %0d assertion, %0d timeout, %0d responses",
             check_errs, sva_errs, timeout_errs, n_rsp);
    if (check_errs == 0 && sva_errs == 0 && timeout_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/mem_ctl_checker.sv ====
// bound assertions on mem_ctl_top for quiet reset, stable R and B, and legal resp codes
`timescale 1ns/10ps
`default_nettype none

module mem_ctl_checker (
  input logic               clk,
  input logic               rst,
  input logic               awready,
  input logic               wready,
  input logic               arready,
  input logic               bvalid,
  input logic               bready,
  input bus_cfg_pkg::resp_t bresp,
  input logic               rvalid,
  input logic               rready,
  input bus_cfg_pkg::data_t rdata,
  input bus_cfg_pkg::resp_t rresp
);

  import bus_cfg_pkg::*;

  // count of failed assertions for the closing line of the testbench
  int assert_errs = 0;

  // nothing offered or taken in the cycle after a reset edge
  reset_quiet: assert property (@(posedge clk)
    rst |=> !bvalid && !rvalid && !awready && !wready && !arready)
    else begin
      assert_errs++;
      $error("valid or ready high right after reset");
    end

  // a stalled response keeps valid and payload
  b_hold: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      assert_errs++;
      $error("B response changed before its transfer");
    end

  r_hold: assert property (@(posedge clk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      assert_errs++;
      $error("R response changed before its transfer");
    end

  // only OKAY and SLVERR are ever produced
  b_code: assert property (@(posedge clk) disable iff (rst)
    bvalid |-> (bresp == resp_okay || bresp == resp_slverr))
    else begin
      assert_errs++;
      $error("illegal bresp code");
    end

  r_code: assert property (@(posedge clk) disable iff (rst)
    rvalid |-> (rresp == resp_okay || rresp == resp_slverr))
    else begin
      assert_errs++;
      $error("illegal rresp code");
    end

endmodule

bind mem_ctl_top mem_ctl_checker chk0 (
  .clk(clk), .rst(rst),
  .awready(awready), .wready(wready), .arready(arready),
  .bvalid(bvalid), .bready(bready), .bresp(bresp),
  .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
);

`default_nettype wire

// ==== verilog/mem_ctl_top.sv ====
// memory controller top: AXI4-Lite ports, front end, request and response slots, array
`timescale 1ns/10ps
`default_nettype none

module mem_ctl_top #(
  parameter int mem_words = 150
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               awvalid,
  output logic               awready,
  input  bus_cfg_pkg::addr_t awaddr,
  input  logic               wvalid,
  output logic               wready,
  input  bus_cfg_pkg::data_t wdata,
  input  bus_cfg_pkg::strb_t wstrb,
  output logic               bvalid,
  input  logic               bready,
  output bus_cfg_pkg::resp_t bresp,
  input  logic               arvalid,
  output logic               arready,
  input  bus_cfg_pkg::addr_t araddr,
  output logic               rvalid,
  input  logic               rready,
  output bus_cfg_pkg::data_t rdata,
  output bus_cfg_pkg::resp_t rresp
);

  import mem_ctl_pkg::*;

  // front -> req slot -> array -> rsp slot -> front
  mem_stream_if #(.payload_t(mem_req_t)) req_a ();
  mem_stream_if #(.payload_t(mem_req_t)) req_b ();
  mem_stream_if #(.payload_t(mem_rsp_t)) rsp_a ();
  mem_stream_if #(.payload_t(mem_rsp_t)) rsp_b ();

  axi_lite_front front0 (
    .clk, .rst,
    .awvalid, .awready, .awaddr,
    .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .arvalid, .arready, .araddr,
    .rvalid, .rready, .rdata, .rresp,
    .req (req_a.source),
    .rsp (rsp_b.sink)
  );

  pipe_stage #(.payload_t(mem_req_t)) req_reg (
    .clk, .rst,
    .up   (req_a.sink),
    .down (req_b.source)
  );

  mem_array_stage #(.mem_words(mem_words)) array0 (
    .clk, .rst,
    .req (req_b.sink),
    .rsp (rsp_a.source)
  );

  pipe_stage #(.payload_t(mem_rsp_t)) rsp_reg (
    .clk, .rst,
    .up   (rsp_a.sink),
    .down (rsp_b.source)
  );

endmodule

`default_nettype wire

// ==== verilog/axi_lite_front.sv ====
// AXI4-Lite slave front end: read-first arbitration, request register, R/B steering
`timescale 1ns/10ps
`default_nettype none

module axi_lite_front (
  input  logic                clk,
  input  logic                rst,

  // write address
  input  logic                awvalid,
  output logic                awready,
  input  bus_cfg_pkg::addr_t  awaddr,

  // write data
  input  logic                wvalid,
  output logic                wready,
  input  bus_cfg_pkg::data_t  wdata,
  input  bus_cfg_pkg::strb_t  wstrb,

  // write response
  output logic                bvalid,
  input  logic                bready,
  output bus_cfg_pkg::resp_t  bresp,

  // read address
  input  logic                arvalid,
  output logic                arready,
  input  bus_cfg_pkg::addr_t  araddr,

  // read data
  output logic                rvalid,
  input  logic                rready,
  output bus_cfg_pkg::data_t  rdata,
  output bus_cfg_pkg::resp_t  rresp,

  // request out, response back
  mem_stream_if.source        req,
  mem_stream_if.sink          rsp
);

  import bus_cfg_pkg::*;
  import mem_ctl_pkg::*;

  // readies stay low until the first cycle after reset
  logic     active;
  // the one request register
  logic     req_valid;
  mem_req_t req_pay;
  // slot is empty or drains this cycle
  logic     slot_free;
  logic     rd_go;
  logic     wr_go;
  logic     rsp_is_read;

  always_ff @(posedge clk) begin
    if (rst) begin
      active <= 1'b0;
    end else begin
      active <= 1'b1;
    end
  end

  assign slot_free = !req_valid || req.ready;

  // reads always win
  assign arready = active && slot_free;
  assign rd_go   = arvalid && arready;

  // AW and W taken together, only with no read waiting
  assign wr_go   = active && slot_free && awvalid && wvalid && !arvalid;
  assign awready = wr_go;
  assign wready  = wr_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else if (rd_go || wr_go) begin
      req_valid <= 1'b1;
    end else if (req.ready) begin
      req_valid <= 1'b0;
    end
  end

  // payload only loads on acceptance
  always_ff @(posedge clk) begin
    if (rd_go) begin
      req_pay.op    <= op_read;
      req_pay.idx   <= araddr[addr_w-1:word_shift];
      req_pay.wdata <= '0;
      req_pay.wstrb <= '0;
    end else if (wr_go) begin
      req_pay.op    <= op_write;
      req_pay.idx   <= awaddr[addr_w-1:word_shift];
      req_pay.wdata <= wdata;
      req_pay.wstrb <= wstrb;
    end
  end

  assign req.valid   = req_valid;
  assign req.payload = req_pay;

  // steer the returning response by its op
  assign rsp_is_read = (rsp.payload.op == op_read);

  assign rvalid = rsp.valid && rsp_is_read;
  assign bvalid = rsp.valid && !rsp_is_read;
  assign rdata  = rsp.payload.rdata;
  assign rresp  = rsp.payload.resp;
  assign bresp  = rsp.payload.resp;

  // ready back from whichever channel the response is headed to
  assign rsp.ready = rsp_is_read ? rready : bready;

endmodule

`default_nettype wire

// ==== verilog/mem_array_stage.sv ====
// memory stage: range check, word array with byte strobes, registered response
`timescale 1ns/10ps
`default_nettype none

module mem_array_stage #(
  parameter int mem_words = 150
) (
  input  logic         clk,
  input  logic         rst,
  mem_stream_if.sink   req,
  mem_stream_if.source rsp
);

  import bus_cfg_pkg::*;
  import mem_ctl_pkg::*;

  // word index width from the bus, array address width from the depth
  localparam int idx_w = addr_w - word_shift;
  localparam int mem_aw = (mem_words > 1) ? $clog2(mem_words) : 1;
  localparam logic [idx_w-1:0] last_idx = idx_w'(mem_words - 1);

  // storage, contents undefined until written
  data_t mem [mem_words];

  logic              go;
  logic              in_range;
  logic [mem_aw-1:0] word_addr;
  // response slot
  logic              rsp_valid;
  mem_rsp_t          rsp_pay;

  // stall when the response slot is full and not draining
  assign req.ready = !rsp_valid || rsp.ready;
  assign go        = req.valid && req.ready;

  // at or beyond depth is refused
  assign in_range  = (req.payload.idx <= last_idx);
  assign word_addr = req.payload.idx[mem_aw-1:0];

  // strobed write, refused writes leave memory alone
  always_ff @(posedge clk) begin
    if (go && in_range && req.payload.op == op_write) begin
      for (int b = 0; b < strb_w; b++) begin
        if (req.payload.wstrb[b]) begin
          mem[word_addr][8*b +: 8] <= req.payload.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else if (req.ready) begin
      rsp_valid <= req.valid;
    end
  end

  // response formed in the same edge as the access
  always_ff @(posedge clk) begin
    if (go) begin
      rsp_pay.op <= req.payload.op;
      if (!in_range) begin
        rsp_pay.rdata <= '0;
        rsp_pay.resp  <= resp_slverr;
      end else if (req.payload.op == op_read) begin
        // old word, a write in this stage cannot overlap
        rsp_pay.rdata <= mem[word_addr];
        rsp_pay.resp  <= resp_okay;
      end else begin
        rsp_pay.rdata <= '0;
        rsp_pay.resp  <= resp_okay;
      end
    end
  end

  assign rsp.valid   = rsp_valid;
  assign rsp.payload = rsp_pay;

endmodule

`default_nettype wire

// ==== verilog/pipe_stage.sv ====
// one-deep registered valid/ready slot, full throughput, typed payload
`timescale 1ns/10ps
`default_nettype none

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic         clk,
  input  logic         rst,
  // upstream side
  mem_stream_if.sink   up,
  // downstream side
  mem_stream_if.source down
);

  // slot state
  logic     full_q;
  payload_t data_q;

  // take new data when empty or when the slot empties this cycle
  assign up.ready = !full_q || down.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (up.ready) begin
      // refill or empty in the same edge
      full_q <= up.valid;
    end
  end

  // data holds while stalled
  always_ff @(posedge clk) begin
    if (up.valid && up.ready) begin
      data_q <= up.payload;
    end
  end

  assign down.valid   = full_q;
  assign down.payload = data_q;

endmodule

`default_nettype wire

// ==== verilog/mem_stream_if.sv ====
// valid/ready stream interface with typed payload, source and sink modports
`timescale 1ns/10ps
`default_nettype none

interface mem_stream_if #(
  parameter type payload_t = logic
) ();

  // transfer on a rising edge with valid and ready both high
  logic     valid;
  logic     ready;
  payload_t payload;

  // producer side, holds valid and payload until transfer
  modport source (
    output valid,
    output payload,
    input  ready
  );

  // consumer side
  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// ==== verilog/mem_ctl_pkg.sv ====
// memory operation enum, internal request and response structs
`default_nettype none

package mem_ctl_pkg;

  // read or write, also picks R or B on the way back
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  // request as it travels from the front end to the array
  typedef struct packed {
    mem_op_e                                               op;
    // word index, byte offset already dropped
    logic [bus_cfg_pkg::addr_w-bus_cfg_pkg::word_shift-1:0] idx;
    // write payload, zero for reads
    bus_cfg_pkg::data_t                                    wdata;
    bus_cfg_pkg::strb_t                                    wstrb;
  } mem_req_t;

  // response on its way back to the front end
  typedef struct packed {
    mem_op_e             op;
    // read word, zero for writes and refused reads
    bus_cfg_pkg::data_t  rdata;
    bus_cfg_pkg::resp_t  resp;
  } mem_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/bus_cfg_pkg.sv ====
// AXI4-Lite bus widths, address/data/strobe types and response codes
`default_nettype none

package bus_cfg_pkg;

  // byte address width on the AXI4-Lite port
  parameter int addr_w = 32;

  // data bus width, one strobe bit per byte
  parameter int data_w = 32;
  parameter int strb_w = data_w / 8;

  // byte address to word index
  parameter int word_shift = 2;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [strb_w-1:0] strb_t;

  // xRESP encoding, only two codes are produced
  typedef logic [1:0] resp_t;

  parameter resp_t resp_okay   = 2'b00;
  // 2'b01 would be EXOKAY, never used on AXI4-Lite
  parameter resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire
